/* hw/spi_frame_pkg.sv */
`default_nettype none

package spi_frame_pkg;

    // Frame layout chosen by the command byte
    typedef enum logic [1:0] {
        cmd_only  = 2'd0,  // Command byte alone
        data_only = 2'd1,  // Data at the current pointer
        addr_only = 2'd2,  // Two address bytes, high first
        addr_data = 2'd3   // Address bytes then data
    } frame_mode_e;

    // Command byte, received LSB first
    typedef struct packed {
        logic [3:0]  rsvd;
        logic        write;  // Data bytes are stored
        logic        cont;   // Data phase repeats
        frame_mode_e mode;
    } cmd_t;

    typedef enum logic [1:0] {
        idle    = 2'd0,
        trans   = 2'd1,
        recover = 2'd2   // Wait for ss high after reset or error
    } ctrl_state_e;

    // Destination of a completed byte
    typedef enum logic [1:0] {
        cmd     = 2'd0,
        addr_hi = 2'd1,
        addr_lo = 2'd2,
        data    = 2'd3
    } field_sel_e;

endpackage

`default_nettype wire

/* hw/spi_bus_pkg.sv */
`default_nettype none

package spi_bus_pkg;

    // Raw SPI pins as seen at the device boundary
    typedef struct packed {
        logic sclk;
        logic ss;
        logic mosi;
    } spi_pins_t;

    // Synchronized pin events, each strobe one clk cycle wide
    typedef struct packed {
        logic sclk_rise;
        logic sclk_fall;
        logic ss_fall;
        logic ss_rise;
        logic ss_low;   // Level
        logic mosi;     // Level
    } spi_strobes_t;

    typedef struct packed {
        logic        we;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* hw/spi_pin_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  spi_bus_pkg::spi_pins_t    pins,
    output spi_bus_pkg::spi_strobes_t strobes
);

    // Bus at rest: sclk low, slave not selected
    localparam spi_bus_pkg::spi_pins_t PINS_IDLE = '{sclk: 1'b0, ss: 1'b1, mosi: 1'b0};

    spi_bus_pkg::spi_pins_t sync_q [SYNC_STAGES];
    spi_bus_pkg::spi_pins_t prev_q;  // Edge detect stage
    spi_bus_pkg::spi_pins_t cur;

    assign cur = sync_q[SYNC_STAGES-1];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= PINS_IDLE;
            end
            prev_q <= PINS_IDLE;
        end else begin
            sync_q[0] <= pins;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            prev_q <= cur;
        end
    end

    always_comb begin
        strobes.sclk_rise = cur.sclk && !prev_q.sclk;
        strobes.sclk_fall = !cur.sclk && prev_q.sclk;
        strobes.ss_fall   = !cur.ss && prev_q.ss;
        strobes.ss_rise   = cur.ss && !prev_q.ss;
        strobes.ss_low    = !cur.ss;
        strobes.mosi      = cur.mosi;
    end

    // SPI mode 0 keeps sclk low whenever ss changes
    ss_edge_sclk_low: assert property (
        @(posedge clk) disable iff (!rst)
        (strobes.ss_fall || strobes.ss_rise) |-> !cur.sclk
    ) else $error("ss changes while sclk is high");

endmodule

`default_nettype wire

/* hw/spi_shift_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_shift_reg (
    input  logic       clk,
    input  logic       rst,
    input  logic       shift_en,
    input  logic       out_en,
    input  logic       load,
    input  logic [7:0] load_data,
    input  logic       bit_in,
    output logic       bit_out,
    output logic [7:0] rx_byte
);

    logic [7:0] rx_q;
    logic [7:0] tx_q;

    // LSB arrives first, so new bits enter at the top
    always_ff @(posedge clk) begin
        if (shift_en) begin
            rx_q <= {bit_in, rx_q[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            tx_q <= 8'h00;  // Keeps miso quiet until the first load
        end else if (load) begin
            tx_q <= load_data;
        end else if (out_en) begin
            tx_q <= {1'b0, tx_q[7:1]};
        end
    end

    assign bit_out = tx_q[0];
    assign rx_byte = rx_q;

    // A load between sclk edges must not collide with a shift
    load_between_edges: assert property (
        @(posedge clk) disable iff (!rst)
        load |-> !(shift_en || out_en)
    ) else $error("transmit load collides with a shift strobe");

endmodule

`default_nettype wire

/* hw/spi_field_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_field_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      frame_start,
    input  logic                      capture,
    input  spi_frame_pkg::field_sel_e field_sel,
    input  logic                      addr_inc,
    input  logic [7:0]                rx_byte,
    output spi_frame_pkg::cmd_t       cmd,
    output logic [15:0]               addr,
    output logic [7:0]                data_out,
    output logic [7:0]                raw_byte
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            cmd      <= '0;
            addr     <= 16'h0000;
            data_out <= 8'h00;
            raw_byte <= 8'h00;
        end else if (frame_start) begin
            // Address pointer survives between frames
            cmd      <= '0;
            data_out <= 8'h00;
            raw_byte <= 8'h00;
        end else if (capture) begin
            raw_byte <= rx_byte;  // Every byte lands here
            case (field_sel)
                spi_frame_pkg::cmd: begin
                    cmd <= spi_frame_pkg::cmd_t'(rx_byte);
                end
                spi_frame_pkg::addr_hi: begin
                    addr[15:8] <= rx_byte;
                end
                spi_frame_pkg::addr_lo: begin
                    addr[7:0] <= rx_byte;
                end
                spi_frame_pkg::data: begin
                    data_out <= rx_byte;
                end
            endcase
        end else if (addr_inc) begin
            addr <= addr + 16'd1;  // Continuous data phase
        end
    end

    // The increment trails the data capture by one cycle
    capture_then_inc: assert property (
        @(posedge clk) disable iff (!rst)
        !(capture && addr_inc)
    ) else $error("capture and address increment in the same cycle");

    data_inc_order: assert property (
        @(posedge clk) disable iff (!rst)
        addr_inc |-> $past(capture) && $past(field_sel) == spi_frame_pkg::data
    ) else $error("address increment without a preceding data capture");

endmodule

`default_nettype wire

/* hw/spi_reg_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_reg_mem #(
    parameter int MEM_AW = 6
) (
    input  logic                  clk,
    input  logic                  rst,
    input  spi_bus_pkg::mem_req_t req,
    output logic [7:0]            rdata
);

    localparam int DEPTH = 2 ** MEM_AW;

    logic [7:0]        mem_q [DEPTH];
    logic [MEM_AW-1:0] word;

    assign word = req.addr[MEM_AW-1:0];  // Upper address bits alias

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= 8'h00;
            end
        end else if (req.we) begin
            mem_q[word] <= req.wdata;
        end
    end

    // Read is combinational so a load sees the address of the same cycle
    assign rdata = mem_q[word];

endmodule

`default_nettype wire

/* hw/spi_frame_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_frame_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  spi_bus_pkg::spi_strobes_t strobes,
    input  logic                      abort,
    input  spi_frame_pkg::cmd_t       cmd,
    input  logic [15:0]               addr,
    input  logic [7:0]                rx_byte,
    output logic                      shift_en,
    output logic                      out_en,
    output logic                      load,
    output logic                      tx_sel,
    output logic                      frame_start,
    output logic                      capture,
    output spi_frame_pkg::field_sel_e field_sel,
    output logic                      addr_inc,
    output spi_bus_pkg::mem_req_t     mem_req,
    output logic                      eob,
    output logic                      eop,
    output logic                      err_out,
    output logic                      busy
);

    spi_frame_pkg::ctrl_state_e state_q;
    spi_frame_pkg::field_sel_e  sel_q;
    logic [2:0] bit_cnt_q;
    logic [1:0] idx_q;        // Byte position in the frame unit
    logic       byte_done_q;
    logic       cap_q;
    logic       post_q;       // Cycle after capture
    logic       end_q;        // Last byte closed a unit
    logic       closed_q;     // Frame takes no more bytes
    logic       we_q;
    logic       inc_q;
    logic       tx_mem_q;     // Next byte is read data
    logic       err_q;

    spi_frame_pkg::cmd_t       rx_cmd;
    spi_frame_pkg::cmd_t       cur_cmd;
    spi_frame_pkg::field_sel_e byte_sel;
    logic [1:0] idx_nxt;
    logic       last;
    logic       next_rd;
    logic       bad_cont;
    logic       in_trans;

    // Decode of the byte that just completed
    always_comb begin
        rx_cmd   = spi_frame_pkg::cmd_t'(rx_byte);
        cur_cmd  = (idx_q == 2'd0) ? rx_cmd : cmd;  // Command not yet captured
        byte_sel = spi_frame_pkg::data;
        idx_nxt  = idx_q;                           // Data bytes repeat in place
        last     = 1'b0;
        case (idx_q)
            2'd0: begin
                byte_sel = spi_frame_pkg::cmd;
                idx_nxt  = 2'd1;
                last     = (cur_cmd.mode == spi_frame_pkg::cmd_only);
            end
            2'd1: begin
                if (cur_cmd.mode == spi_frame_pkg::data_only) begin
                    last = 1'b1;
                end else begin
                    byte_sel = spi_frame_pkg::addr_hi;
                    idx_nxt  = 2'd2;
                end
            end
            2'd2: begin
                byte_sel = spi_frame_pkg::addr_lo;
                idx_nxt  = 2'd3;
                last     = (cur_cmd.mode == spi_frame_pkg::addr_only);
            end
            default: last = 1'b1;
        endcase
        bad_cont = (idx_q == 2'd0) && rx_cmd.cont &&
                   (rx_cmd.mode == spi_frame_pkg::cmd_only ||
                    rx_cmd.mode == spi_frame_pkg::addr_only);
        next_rd  = !cur_cmd.write &&
                   (cur_cmd.mode == spi_frame_pkg::data_only ||
                    (cur_cmd.mode == spi_frame_pkg::addr_data && idx_q >= 2'd2));
    end

    assign in_trans    = (state_q == spi_frame_pkg::trans);
    assign shift_en    = in_trans && strobes.sclk_rise && !closed_q;
    // Fall after the eighth rise presents bit 0 of the freshly loaded byte
    assign out_en      = in_trans && strobes.sclk_fall && (bit_cnt_q != 3'd0);
    assign frame_start = (state_q == spi_frame_pkg::idle) && strobes.ss_fall;
    assign load        = frame_start || post_q;  // Status first, then per byte
    assign tx_sel      = post_q && tx_mem_q;
    assign capture     = cap_q;
    assign eob         = cap_q;
    assign eop         = cap_q && end_q;
    assign field_sel   = sel_q;
    assign addr_inc    = post_q && inc_q;
    assign err_out     = err_q;
    assign busy        = in_trans;

    always_comb begin
        mem_req.we    = cap_q && we_q;
        mem_req.addr  = addr + {15'd0, addr_inc};  // Read ahead to the next pointer
        mem_req.wdata = rx_byte;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q     <= spi_frame_pkg::recover;
            sel_q       <= spi_frame_pkg::cmd;
            bit_cnt_q   <= 3'd0;
            idx_q       <= 2'd0;
            byte_done_q <= 1'b0;
            cap_q       <= 1'b0;
            post_q      <= 1'b0;
            end_q       <= 1'b0;
            closed_q    <= 1'b0;
            we_q        <= 1'b0;
            inc_q       <= 1'b0;
            tx_mem_q    <= 1'b0;
            err_q       <= 1'b0;
        end else begin
            byte_done_q <= 1'b0;
            cap_q       <= byte_done_q;
            post_q      <= cap_q;
            case (state_q)
                spi_frame_pkg::idle: begin
                    if (strobes.ss_fall) begin
                        state_q   <= spi_frame_pkg::trans;
                        err_q     <= 1'b0;  // Error holds until here
                        bit_cnt_q <= 3'd0;
                        idx_q     <= 2'd0;
                        end_q     <= 1'b0;
                        closed_q  <= 1'b0;
                    end
                end
                spi_frame_pkg::trans: begin
                    if (byte_done_q) begin
                        sel_q    <= byte_sel;
                        idx_q    <= idx_nxt;
                        end_q    <= last;
                        closed_q <= last && !cur_cmd.cont;
                        we_q     <= (byte_sel == spi_frame_pkg::data) && cur_cmd.write;
                        inc_q    <= (byte_sel == spi_frame_pkg::data) && cur_cmd.cont;
                        tx_mem_q <= next_rd;
                    end
                    if (abort || (byte_done_q && bad_cont)) begin
                        state_q <= spi_frame_pkg::recover;
                        err_q   <= 1'b1;
                    end else if (strobes.ss_rise) begin
                        // Mid byte or before the unit is complete
                        if (bit_cnt_q != 3'd0 || !end_q) begin
                            err_q <= 1'b1;
                            state_q <= spi_frame_pkg::recover;
                        end else begin
                            state_q <= spi_frame_pkg::idle;
                        end
                    end else if (strobes.sclk_rise) begin
                        if (closed_q) begin
                            err_q   <= 1'b1;  // Byte past the end of the frame
                            state_q <= spi_frame_pkg::recover;
                        end else begin
                            bit_cnt_q   <= bit_cnt_q + 3'd1;
                            end_q       <= 1'b0;
                            byte_done_q <= (bit_cnt_q == 3'd7);
                        end
                    end
                end
                default: begin
                    if (!strobes.ss_low) begin
                        state_q <= spi_frame_pkg::idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/spi_slave_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave_top #(
    parameter int SYNC_STAGES = 2,
    parameter int MEM_AW      = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  spi_bus_pkg::spi_pins_t pins,
    input  logic [7:0]             status,
    input  logic                   abort,
    output logic                   miso,
    output spi_frame_pkg::cmd_t    cmd,
    output logic [15:0]            addr,
    output logic [7:0]             data_out,
    output logic [7:0]             raw_byte,
    output logic                   eob,
    output logic                   eop,
    output logic                   err_out,
    output logic                   busy
);

    spi_bus_pkg::spi_strobes_t strobes;
    spi_bus_pkg::mem_req_t     mem_req;
    spi_frame_pkg::field_sel_e field_sel;
    logic       shift_en;
    logic       out_en;
    logic       load;
    logic       tx_sel;
    logic       frame_start;
    logic       capture;
    logic       addr_inc;
    logic [7:0] rx_byte;
    logic [7:0] mem_rdata;
    logic [7:0] tx_data;

    assign tx_data = tx_sel ? mem_rdata : status;  // Register content or status

    spi_pin_sync #(.SYNC_STAGES(SYNC_STAGES)) pin_sync_i (
        .clk(clk), .rst(rst), .pins(pins), .strobes(strobes)
    );

    spi_shift_reg shift_reg_i (
        .clk(clk), .rst(rst), .shift_en(shift_en), .out_en(out_en), .load(load),
        .load_data(tx_data), .bit_in(strobes.mosi), .bit_out(miso), .rx_byte(rx_byte)
    );

    spi_field_regs field_regs_i (
        .clk(clk), .rst(rst), .frame_start(frame_start), .capture(capture),
        .field_sel(field_sel), .addr_inc(addr_inc), .rx_byte(rx_byte),
        .cmd(cmd), .addr(addr), .data_out(data_out), .raw_byte(raw_byte)
    );

    spi_reg_mem #(.MEM_AW(MEM_AW)) reg_mem_i (
        .clk(clk), .rst(rst), .req(mem_req), .rdata(mem_rdata)
    );

    spi_frame_ctrl frame_ctrl_i (
        .clk(clk), .rst(rst), .strobes(strobes), .abort(abort), .cmd(cmd), .addr(addr),
        .rx_byte(rx_byte), .shift_en(shift_en), .out_en(out_en), .load(load),
        .tx_sel(tx_sel), .frame_start(frame_start), .capture(capture),
        .field_sel(field_sel), .addr_inc(addr_inc), .mem_req(mem_req), .eob(eob),
        .eop(eop), .err_out(err_out), .busy(busy)
    );

endmodule

`default_nettype wire

/* verification/spi_slave_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave_tb;

    localparam int PHASE     = 8;   // clk cycles per SCLK phase
    localparam int EOB_LIMIT = 40;
    localparam int NFIELDS   = 19;

    logic                   clk;
    logic                   rst;
    spi_bus_pkg::spi_pins_t pins;
    logic [7:0]             status;
    logic                   abort;
    logic                   miso;
    spi_frame_pkg::cmd_t    cmd;
    logic [15:0]            addr;
    logic [7:0]             data_out;
    logic [7:0]             raw_byte;
    logic                   eob;
    logic                   eop;
    logic                   err_out;
    logic                   busy;

    int seed = 90;

    spi_slave_top #(.SYNC_STAGES(2), .MEM_AW(6)) dut_i (
        .clk(clk), .rst(rst), .pins(pins), .status(status), .abort(abort),
        .miso(miso), .cmd(cmd), .addr(addr), .data_out(data_out), .raw_byte(raw_byte),
        .eob(eob), .eop(eop), .err_out(err_out), .busy(busy)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_cmd(input string name, input spi_frame_pkg::cmd_t got,
                             input spi_frame_pkg::cmd_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // Whether byte idx closes a frame unit, from the command layout
    function automatic logic unit_end(input spi_frame_pkg::cmd_t c, input int idx);
        case (c.mode)
            spi_frame_pkg::cmd_only:  return idx == 0;
            spi_frame_pkg::data_only: return idx >= 1;
            spi_frame_pkg::addr_only: return idx == 2;
            default:                  return idx >= 3;
        endcase
    endfunction

    task automatic wait_eob(input logic exp_eop);
        int n;
        n = 0;
        while (!eob) begin
            if (n == EOB_LIMIT) begin
                fail_run("timeout waiting for the end-of-byte pulse");
            end
            @(negedge clk);
            n++;
        end
        check_flag("eop", eop, exp_eop);  // eop rides on the same cycle
    endtask

    // Shifts nbits of tx out LSB first, samples miso before each rise
    task automatic send_bits(input logic [7:0] tx, input int nbits, input logic [7:0] exp_miso,
                             input logic chk_miso, input logic want_eob, input logic exp_eop);
        logic [7:0] rx;
        rx = 8'h00;
        for (int i = 0; i < nbits; i++) begin
            pins.sclk = 1'b0;
            pins.mosi = tx[i];
            repeat (PHASE) @(negedge clk);
            rx[i] = miso;
            pins.sclk = 1'b1;
            if (i == 7 && want_eob) begin
                wait_eob(exp_eop);
            end
            repeat (PHASE) @(negedge clk);
        end
        if (chk_miso) begin
            check_byte("miso", rx, exp_miso);
        end
    endtask

    // Kind 0 normal, 1 extra byte, 2 ss rises mid byte, 3 abort
    task automatic run_frame(input int f[NFIELDS]);
        int                  kind;
        int                  n;
        int                  m;
        int                  last_b;
        logic [7:0]          st;
        logic                extra;
        logic                early_err;
        spi_frame_pkg::cmd_t c;
        kind = f[0];
        n    = f[1];
        early_err = (kind == 1) || (kind == 3);  // Flagged while ss is still low
        last_b    = (kind == 1) ? n - 2 : n - 1;  // Last byte that completed
        if (f[8] == 'h1ff) begin
            st = 8'($random(seed));  // Filler line
        end else begin
            st = 8'(f[8]);
        end
        c = spi_frame_pkg::cmd_t'(8'(f[2]));
        check_flag("busy", busy, 1'b0);
        status  = st;
        pins.ss = 1'b0;
        repeat (PHASE) @(negedge clk);
        check_flag("err_out", err_out, 1'b0);  // Cleared by ss fall
        check_flag("busy", busy, 1'b1);
        for (int b = 0; b < n; b++) begin
            extra = (kind == 1) && (b == n - 1);
            m     = f[9 + b];
            send_bits(8'(f[2 + b]), 8, (m == 'h1ff) ? st : 8'(m),
                      (m != 'h100) && !extra, !extra, unit_end(c, b));
        end
        if (kind == 2) begin
            send_bits(8'h00, 3, 8'h00, 1'b0, 1'b0, 1'b0);
        end
        if (kind == 3) begin
            abort = 1'b1;
            repeat (2) @(negedge clk);
            abort = 1'b0;
        end
        pins.sclk = 1'b0;
        repeat (PHASE) @(negedge clk);
        check_flag("err_out", err_out, early_err);
        check_flag("busy", busy, !early_err);
        pins.ss = 1'b1;
        repeat (PHASE) @(negedge clk);
        check_cmd("cmd", cmd, spi_frame_pkg::cmd_t'(8'(f[15])));
        check_addr("addr", addr, 16'(f[16]));
        check_byte("data_out", data_out, 8'(f[17]));
        check_byte("raw_byte", raw_byte, 8'(f[2 + last_b]));
        check_flag("err_out", err_out, f[18] != 0);
        check_flag("busy", busy, 1'b0);
    endtask

    initial begin
        int    fd;
        int    rc;
        int    frames;
        int    f[NFIELDS];
        string line;
        rst       = 1'b0;
        pins.sclk = 1'b0;
        pins.ss   = 1'b1;
        pins.mosi = 1'b0;
        status    = 8'h00;
        abort     = 1'b0;
        frames    = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        repeat (PHASE) @(negedge clk);

        fd = $fopen("verification/spi_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the test data file");
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 1 && line[0] != "#") begin
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                             f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
                if (rc != NFIELDS) begin
                    fail_run("test data line has the wrong number of fields");
                end
                run_frame(f);
                frames++;
            end
        end
        $fclose(fd);
        if (frames == 0) begin
            fail_run("no frames were read from the test data file");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verification/spi_testdata.txt */
# kind n b0..b5 status miso0..miso5 cmd addr data err (hex; status 1ff random, miso 1ff status)
# kind 0 normal, 1 extra byte, 2 ss mid byte, 3 abort; miso 100 is not checked
0 1 F0 00 00 00 00 00 A5 A5 100 100 100 100 100 F0 0000 00 0
0 4 0B 00 12 5C 00 00 3C 3C 3C 3C 3C 100 100 0B 0012 5C 0
0 4 03 00 12 00 00 00 81 81 81 81 5C 100 100 03 0012 00 0
0 4 0D 11 22 33 00 00 44 44 44 44 44 100 100 0D 0015 33 0
0 6 07 00 12 00 00 00 66 66 66 66 11 22 33 07 0015 00 0
0 3 02 00 13 00 00 00 77 77 77 77 100 100 100 02 0013 00 0
0 2 01 AB 00 00 00 00 99 99 22 100 100 100 100 01 0013 AB 0
2 1 03 00 00 00 00 00 5A 5A 100 100 100 100 100 03 0013 00 1
0 1 00 00 00 00 00 00 1ff 1ff 100 100 100 100 100 00 0013 00 0
1 2 00 55 00 00 00 00 E1 E1 100 100 100 100 100 00 0013 00 1
0 2 01 00 00 00 00 00 1ff 1ff 22 100 100 100 100 01 0013 00 0
3 2 03 00 00 00 00 00 C3 C3 C3 100 100 100 100 03 0013 00 1
0 1 00 00 00 00 00 00 1ff 1ff 100 100 100 100 100 00 0013 00 0

/* flist.f */
hw/spi_frame_pkg.sv
hw/spi_bus_pkg.sv
hw/spi_pin_sync.sv
hw/spi_shift_reg.sv
hw/spi_field_regs.sv
hw/spi_reg_mem.sv
hw/spi_frame_ctrl.sv
hw/spi_slave_top.sv
verification/spi_slave_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spi_slave_tb \
    -f flist.f --Mdir obj_dir -o sim_spi

./obj_dir/sim_spi | tee sim.log

if grep -q "No errors" sim.log; then
    exit 0
fi
exit 1
